// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

   // address split, most significant first: tag | line index | word offset
   localparam int addr_w     = 12;
   localparam int data_w     = 32;
   localparam int word_off_w = 2;
   localparam int line_idx_w = 4;
   localparam int tag_w      = addr_w - line_idx_w - word_off_w;

   typedef logic [addr_w-1:0]     word_addr_t;
   typedef logic [data_w-1:0]     data_t;
   // all zeros means read
   typedef logic [data_w/8-1:0]   wstrb_t;
   typedef logic [line_idx_w-1:0] line_idx_t;
   typedef logic [word_off_w-1:0] word_off_t;
   typedef logic [tag_w-1:0]      tag_t;

   // one back-end access, valid for a single cycle
   typedef struct packed {
      logic       valid;
      word_addr_t addr;
      data_t      wdata;
      wstrb_t     wstrb;
   } be_req_t;

   typedef enum logic [2:0] {
      idle,
      lookup,
      fill_req,
      fill_wait,
      write_req,
      write_wait,
      respond
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: cache_line_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_line_store
   import cache_pkg::*;
#(
   parameter int ADDR_W     = addr_w,
   parameter int DATA_W     = data_w,
   parameter int LINE_IDX_W = line_idx_w,
   parameter int WORD_OFF_W = word_off_w
) (
   input  logic                                    clk,
   input  logic                                    reset,

   input  logic [LINE_IDX_W-1:0]                   look_idx,
   input  logic [WORD_OFF_W-1:0]                   look_off,

   input  logic                                    wr_en,
   input  logic                                    wr_fill,
   input  logic [WORD_OFF_W-1:0]                   wr_off,
   input  data_t                                   wr_data,
   input  wstrb_t                                  wr_strb,
   input  logic [ADDR_W-LINE_IDX_W-WORD_OFF_W-1:0] wr_tag,
   input  logic                                    clear_all,

   output logic [ADDR_W-LINE_IDX_W-WORD_OFF_W-1:0] store_tag,
   output logic                                    store_valid,
   output data_t                                   store_word
);

   localparam int TAG_W  = ADDR_W - LINE_IDX_W - WORD_OFF_W;
   localparam int NLINES = 2 ** LINE_IDX_W;
   localparam int NWORDS = 2 ** WORD_OFF_W;
   localparam int NBYTES = DATA_W / 8;

   logic [NLINES-1:0] valid_q;
   logic [TAG_W-1:0]  tag_mem [NLINES];
   data_t             data_mem [NLINES][NWORDS];

   // line becomes valid only with its last fill word
   always_ff @(posedge clk) begin
      if (reset || clear_all) begin
         valid_q <= '0;
      end else if (wr_en && wr_fill) begin
         valid_q[look_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && wr_fill) begin
         tag_mem[look_idx] <= wr_tag;
      end
   end

   // byte lanes, full strobes on fill
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wr_strb[b]) begin
               data_mem[look_idx][wr_off][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
   end

   assign store_tag   = tag_mem[look_idx];
   assign store_valid = valid_q[look_idx];
   assign store_word  = data_mem[look_idx][look_off];

endmodule

`default_nettype wire

// File: cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller
   import cache_pkg::*;
#(
   parameter int ADDR_W     = addr_w,
   parameter int LINE_IDX_W = line_idx_w,
   parameter int WORD_OFF_W = word_off_w
) (
   input  logic                                    clk,
   input  logic                                    reset,

   // front end
   input  logic                                    req,
   input  word_addr_t                              addr,
   input  data_t                                   wdata,
   input  wstrb_t                                  wstrb,
   output data_t                                   rdata,
   output logic                                    ack,
   input  logic                                    invalidate,

   // line store
   input  logic [ADDR_W-LINE_IDX_W-WORD_OFF_W-1:0] store_tag,
   input  logic                                    store_valid,
   input  data_t                                   store_word,
   output logic [LINE_IDX_W-1:0]                   look_idx,
   output logic [WORD_OFF_W-1:0]                   look_off,
   output logic                                    wr_en,
   output logic                                    wr_fill,
   output logic [WORD_OFF_W-1:0]                   wr_off,
   output data_t                                   wr_data,
   output wstrb_t                                  wr_strb,
   output logic                                    clear_all,

   // back end
   output be_req_t                                 be_req,
   input  data_t                                   be_rdata,
   input  logic                                    be_ack
);

   localparam int TAG_W = ADDR_W - LINE_IDX_W - WORD_OFF_W;

   ctrl_state_t state;
   ctrl_state_t state_next;

   word_addr_t addr_q;
   data_t      wdata_q;
   wstrb_t     wstrb_q;
   data_t      rdata_q;

   logic [WORD_OFF_W-1:0] fill_cnt;

   logic [TAG_W-1:0]      req_tag;
   logic [LINE_IDX_W-1:0] req_idx;
   logic [WORD_OFF_W-1:0] req_off;
   logic                  is_write;
   logic                  hit;
   logic                  fill_last;
   logic                  fill_done;

   assign req_tag   = addr_q[ADDR_W-1 -: TAG_W];
   assign req_idx   = addr_q[WORD_OFF_W +: LINE_IDX_W];
   assign req_off   = addr_q[WORD_OFF_W-1:0];
   assign is_write  = |wstrb_q;
   assign hit       = store_valid && (store_tag == req_tag);
   assign fill_last = &fill_cnt;
   assign fill_done = (state == fill_wait) && be_ack;

   assign look_idx  = req_idx;
   assign look_off  = req_off;
   assign ack       = (state == respond);
   assign rdata     = rdata_q;
   // only taken while no request is in progress
   assign clear_all = (state == idle) && invalidate;

   always_comb begin
      state_next = state;
      case (state)
         idle: begin
            if (req) begin
               state_next = lookup;
            end
         end
         lookup: begin
            if (is_write) begin
               state_next = write_req;
            end else if (hit) begin
               state_next = respond;
            end else begin
               state_next = fill_req;
            end
         end
         fill_req:   state_next = fill_wait;
         fill_wait: begin
            if (be_ack) begin
               state_next = fill_last ? respond : fill_req;
            end
         end
         write_req:  state_next = write_wait;
         write_wait: begin
            if (be_ack) begin
               state_next = respond;
            end
         end
         respond:    state_next = idle;
         default:    state_next = idle;
      endcase
   end

   // write hit updates the line, fill words arrive one by one
   always_comb begin
      wr_en   = 1'b0;
      wr_fill = 1'b0;
      wr_off  = req_off;
      wr_data = wdata_q;
      wr_strb = wstrb_q;
      if (state == lookup && is_write && hit) begin
         wr_en = 1'b1;
      end else if (fill_done) begin
         wr_en   = 1'b1;
         wr_fill = fill_last;
         wr_off  = fill_cnt;
         wr_data = be_rdata;
         wr_strb = '1;
      end
   end

   always_comb begin
      be_req.valid = (state == fill_req) || (state == write_req);
      be_req.wdata = wdata_q;
      if (state == fill_req) begin
         be_req.addr  = {req_tag, req_idx, fill_cnt};
         be_req.wstrb = '0;
      end else begin
         be_req.addr  = addr_q;
         be_req.wstrb = wstrb_q;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= idle;
         fill_cnt <= '0;
      end else begin
         state <= state_next;
         if (state == lookup) begin
            fill_cnt <= '0;
         end else if (fill_done) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == idle && req) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
      if (state == lookup && !is_write && hit) begin
         rdata_q <= store_word;
      end else if (fill_done && fill_cnt == req_off) begin
         // requested word passes by during the fill
         rdata_q <= be_rdata;
      end
   end

endmodule

`default_nettype wire

// File: backing_ram.sv
`timescale 1ns/1ps
`default_nettype none

module backing_ram
   import cache_pkg::*;
#(
   parameter int ADDR_W = addr_w,
   parameter int DATA_W = data_w
) (
   input  logic    clk,
   input  logic    reset,
   input  be_req_t be_req,
   output data_t   be_rdata,
   output logic    be_ack
);

   localparam int DEPTH  = 2 ** ADDR_W;
   localparam int NBYTES = DATA_W / 8;

   data_t mem [DEPTH];

   // memory starts out cleared in simulation
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // read returns the old word on a write
   always @(posedge clk) begin
      if (be_req.valid) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (be_req.wstrb[b]) begin
               mem[be_req.addr][8*b +: 8] <= be_req.wdata[8*b +: 8];
            end
         end
         be_rdata <= mem[be_req.addr];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         be_ack <= 1'b0;
      end else begin
         be_ack <= be_req.valid;
      end
   end

endmodule

`default_nettype wire

// File: cache_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module cache_wrapper
   import cache_pkg::*;
#(
   parameter int ADDR_W     = addr_w,
   parameter int DATA_W     = data_w,
   parameter int LINE_IDX_W = line_idx_w,
   parameter int WORD_OFF_W = word_off_w
) (
   input  logic       clk,
   input  logic       reset,

   input  logic       req,
   input  word_addr_t addr,
   input  data_t      wdata,
   input  wstrb_t     wstrb,
   output data_t      rdata,
   output logic       ack,

   input  logic       invalidate
);

   localparam int TAG_W = ADDR_W - LINE_IDX_W - WORD_OFF_W;

   logic [LINE_IDX_W-1:0] look_idx;
   logic [WORD_OFF_W-1:0] look_off;
   logic [TAG_W-1:0]      store_tag;
   logic                  store_valid;
   data_t                 store_word;
   logic                  wr_en;
   logic                  wr_fill;
   logic [WORD_OFF_W-1:0] wr_off;
   data_t                 wr_data;
   wstrb_t                wr_strb;
   logic                  clear_all;

   be_req_t be_req;
   data_t   be_rdata;
   logic    be_ack;

   cache_controller #(
      .ADDR_W     (ADDR_W),
      .LINE_IDX_W (LINE_IDX_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) cache_controller_i (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .addr        (addr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata       (rdata),
      .ack         (ack),
      .invalidate  (invalidate),
      .store_tag   (store_tag),
      .store_valid (store_valid),
      .store_word  (store_word),
      .look_idx    (look_idx),
      .look_off    (look_off),
      .wr_en       (wr_en),
      .wr_fill     (wr_fill),
      .wr_off      (wr_off),
      .wr_data     (wr_data),
      .wr_strb     (wr_strb),
      .clear_all   (clear_all),
      .be_req      (be_req),
      .be_rdata    (be_rdata),
      .be_ack      (be_ack)
   );

   // front-end address is held until ack, so its tag is still valid on the last fill word
   cache_line_store #(
      .ADDR_W     (ADDR_W),
      .DATA_W     (DATA_W),
      .LINE_IDX_W (LINE_IDX_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) cache_line_store_i (
      .clk         (clk),
      .reset       (reset),
      .look_idx    (look_idx),
      .look_off    (look_off),
      .wr_en       (wr_en),
      .wr_fill     (wr_fill),
      .wr_off      (wr_off),
      .wr_data     (wr_data),
      .wr_strb     (wr_strb),
      .wr_tag      (addr[ADDR_W-1 -: TAG_W]),
      .clear_all   (clear_all),
      .store_tag   (store_tag),
      .store_valid (store_valid),
      .store_word  (store_word)
   );

   backing_ram #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) backing_ram_i (
      .clk      (clk),
      .reset    (reset),
      .be_req   (be_req),
      .be_rdata (be_rdata),
      .be_ack   (be_ack)
   );

endmodule

`default_nettype wire

// File: tb_cache_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_wrapper
   import cache_pkg::*;
;

   localparam int hit_lat           = 2;
   localparam int total_accesses    = 240;
   localparam int cycles_per_access = 16;
   localparam int cycle_limit       = total_accesses * cycles_per_access + 20;
   localparam int mem_words         = 2 ** addr_w;

   logic       clk;
   logic       reset;
   logic       req;
   word_addr_t addr;
   data_t      wdata;
   wstrb_t     wstrb;
   data_t      rdata;
   logic       ack;
   logic       invalidate;

   data_t  shadow [mem_words];
   integer seed = 38537;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;

   cache_wrapper cache_wrapper_i (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .invalidate (invalidate)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // byte lanes with a set strobe take the new data
   function automatic data_t merge_bytes(data_t old_word, data_t new_word, wstrb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < data_w / 8; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   // tag | line index | word offset
   function automatic word_addr_t make_addr(int tag, int idx, int off);
      return word_addr_t'((tag << (line_idx_w + word_off_w)) | (idx << word_off_w) | off);
   endfunction

   // called on a falling edge with the cache idle, returns on the idle edge after ack
   task automatic access(input word_addr_t a, input data_t d, input wstrb_t s,
                         output data_t rd, output int lat);
      req   = 1'b1;
      addr  = a;
      wdata = d;
      wstrb = s;
      lat   = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!ack);
      rd    = rdata;
      req   = 1'b0;
      wstrb = '0;
      @(negedge clk);
      if (ack) begin
         errors++;
         $display("Error at %0t: ack held longer than one cycle for %h", $time, a);
      end
      if (s != '0) begin
         shadow[a] = merge_bytes(shadow[a], d, s);
      end
   endtask

   task automatic write_word(input word_addr_t a, input data_t d, input wstrb_t s);
      data_t rd;
      int    lat;
      access(a, d, s, rd, lat);
   endtask

   task automatic read_check(input word_addr_t a, output int lat);
      data_t rd;
      access(a, '0, '0, rd, lat);
      checks++;
      if (rd !== shadow[a]) begin
         errors++;
         $display("Error at %0t: read %h got %h, expected %h", $time, a, rd, shadow[a]);
      end
   endtask

   task automatic pulse_invalidate;
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
   endtask

   // misses fill the line from memory
   task automatic test_write_read_back;
      int lat;
      for (int i = 0; i < 8; i++) begin
         write_word(word_addr_t'(12'h100 + i * 5), $random(seed), 4'hf);
      end
      for (int i = 0; i < 8; i++) begin
         read_check(word_addr_t'(12'h100 + i * 5), lat);
      end
   endtask

   task automatic test_hit_latency;
      word_addr_t a;
      int         lat;
      a = make_addr(10, 8, 1);
      write_word(a, $random(seed), 4'hf);
      write_word(a + 1, $random(seed), 4'hf);
      read_check(a, lat);
      if (lat <= hit_lat) begin
         errors++;
         $display("Error at %0t: first read of %h acked at hit latency", $time, a);
      end
      read_check(a, lat);
      if (lat != hit_lat) begin
         errors++;
         $display("Error at %0t: hit on %h took %0d cycles, expected %0d",
                  $time, a, lat, hit_lat);
      end
   endtask

   // line from test_hit_latency is still cached
   task automatic test_partial_writes;
      word_addr_t a;
      int         lat;
      a = make_addr(10, 8, 1);
      write_word(a, $random(seed), 4'b0101);
      read_check(a, lat);
      if (lat != hit_lat) begin
         errors++;
         $display("Error at %0t: read of %h after write hit missed", $time, a);
      end
      write_word(a, $random(seed), 4'b1000);
      read_check(a, lat);
      read_check(a + 1, lat);
      if (lat != hit_lat) begin
         errors++;
         $display("Error at %0t: neighbour word %h no longer cached", $time, a + 1);
      end
   endtask

   task automatic test_conflict;
      word_addr_t a0;
      word_addr_t a1;
      int         lat;
      a0 = make_addr(5, 3, 2);
      a1 = make_addr(9, 3, 2);
      write_word(a0, $random(seed), 4'hf);
      write_word(a1, $random(seed), 4'hf);
      for (int i = 0; i < 6; i++) begin
         read_check((i % 2 == 0) ? a0 : a1, lat);
         if (lat <= hit_lat) begin
            errors++;
            $display("Error at %0t: conflicting read %0d hit the cache", $time, i);
         end
      end
   endtask

   task automatic test_invalidate;
      word_addr_t a;
      int         lat;
      a = make_addr(20, 12, 3);
      write_word(a, $random(seed), 4'hf);
      read_check(a, lat);
      read_check(a, lat);
      if (lat != hit_lat) begin
         errors++;
         $display("Error at %0t: %h not cached before invalidate", $time, a);
      end
      pulse_invalidate();
      read_check(a, lat);
      if (lat <= hit_lat) begin
         errors++;
         $display("Error at %0t: read of %h hit after invalidate", $time, a);
      end
   endtask

   // small address range so hits, misses and conflicts all occur
   task automatic test_random_mix;
      word_addr_t a;
      wstrb_t     s;
      int         lat;
      for (int i = 0; i < 200; i++) begin
         a = word_addr_t'($random(seed) & 32'h0ff);
         s = wstrb_t'($random(seed));
         if (($random(seed) & 1) == 0) begin
            read_check(a, lat);
         end else begin
            if (s == '0) begin
               s = '1;
            end
            write_word(a, $random(seed), s);
         end
      end
   endtask

   initial begin
      for (int i = 0; i < mem_words; i++) begin
         shadow[i] = '0;
      end
      reset      = 1'b1;
      req        = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      invalidate = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (ack !== 1'b0) begin
         errors++;
         $display("Error at %0t: ack not low after reset", $time);
      end
      test_write_read_back();
      test_hit_latency();
      test_partial_writes();
      test_conflict();
      test_invalidate();
      test_random_mix();
      $display("reads checked: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
cache_pkg.sv
cache_line_store.sv
cache_controller.sv
backing_ram.sv
cache_wrapper.sv
tb_cache_wrapper.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass message in sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_cache_wrapper \
   -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || echo "build or run failed, see build.log and sim.log"
grep -q "Simulation finished: PASS" sim.log \
   && echo "result: pass" \
   || { echo "result: fail"; exit 1; }
exit 0
